/* src.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/cache_ram.sv
hdl/set_state.sv
hdl/miss_ctrl.sv
hdl/dcache.sv
bench/mem_model.sv
bench/tb_dcache.sv

/* Makefile */
# Verilator build and run of the dcache testbench

SRCS := $(shell grep -v '^+' src.f) hdl/dcache_params.svh

obj_dir/Vtb_dcache: src.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ns -f src.f --top-module tb_dcache

run: obj_dir/Vtb_dcache
	./obj_dir/Vtb_dcache | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* bench/tb_dcache.sv */
`default_nettype none

module tb_dcache;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int MEM_WORDS = 16384;
    // 300 random accesses at up to ~50 cycles each plus the directed ones
    localparam int MAX_CYCLES = 20000;

    logic        clk = 1'b0;
    logic        rst;
    logic        req;
    logic        we;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        stall;

    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata_m;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic [2:0]  awsize;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata_m;
    logic [3:0]  wstrb_m;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;

    logic        hold = 1'b0;
    logic [31:0] peek_addr;
    logic [31:0] peek_data;

    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] delay_seed = 32'd71;
    logic [31:0] test_seed;

    // bus activity so far
    int          ar_count = 0;
    int          aw_count = 0;
    int          w_beats = 0;
    int          w_pos = 0;
    logic [31:0] last_araddr = '0;
    logic [7:0]  last_arlen = '0;
    logic [31:0] last_awaddr = '0;
    int          cycles = 0;

    dcache i_dut (
        .clk (clk), .rst (rst),
        .req (req), .we (we), .wstrb (wstrb), .addr (addr), .wdata (wdata),
        .rdata (rdata), .stall (stall),
        .araddr (araddr), .arlen (arlen), .arsize (arsize), .arvalid (arvalid),
        .arready (arready), .rdata_m (rdata_m), .rlast (rlast), .rvalid (rvalid),
        .rready (rready), .awaddr (awaddr), .awlen (awlen), .awsize (awsize),
        .awvalid (awvalid), .awready (awready), .wdata_m (wdata_m), .wstrb_m (wstrb_m),
        .wlast (wlast), .wvalid (wvalid), .wready (wready), .bvalid (bvalid)
    );

    mem_model i_mem (
        .clk (clk), .rst (rst), .hold (hold),
        .araddr (araddr), .arlen (arlen), .arvalid (arvalid), .arready (arready),
        .rdata_m (rdata_m), .rlast (rlast), .rvalid (rvalid), .rready (rready),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata_m (wdata_m), .wstrb_m (wstrb_m), .wlast (wlast), .wvalid (wvalid),
        .wready (wready), .bvalid (bvalid),
        .peek_addr (peek_addr), .peek_data (peek_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // same preload rule as the memory model
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h0bad_f00d;
    endfunction

    function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (new_w & mask) | (old_w & ~mask);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // starts and ends on a falling edge with stall low
    task automatic access(input logic st, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] strb);
        logic [31:0] exp_word;
        int          idx;
        idx = int'(a[15:2]);
        if (st) begin
            ref_mem[idx] = byte_merge(ref_mem[idx], d, strb);
        end
        exp_word = ref_mem[idx];
        req = 1'b1;
        we = st;
        wstrb = strb;
        addr = a;
        wdata = d;
        @(posedge clk);
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        req = 1'b0;
        check_value("rdata", rdata, exp_word);
    endtask

    task automatic load(input logic [31:0] a);
        access(1'b0, a, 32'd0, 4'h0);
    endtask

    task automatic store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] strb);
        access(1'b1, a, d, strb);
    endtask

    task automatic check_line_in_memory(input logic [31:0] line_addr);
        for (int w = 0; w < 8; w++) begin
            peek_addr = line_addr + 32'(w * 4);
            @(negedge clk);
            check_value("memory word", peek_data, ref_mem[int'(peek_addr[15:2])]);
        end
    endtask

    task automatic idle_after_reset();
        check_value("stall", 32'(stall), 32'd0);
        check_value("arvalid", 32'(arvalid), 32'd0);
        check_value("rready", 32'(rready), 32'd0);
        check_value("awvalid", 32'(awvalid), 32'd0);
        check_value("wvalid", 32'(wvalid), 32'd0);
    endtask

    task automatic cold_load();
        int ar0;
        ar0 = ar_count;
        load(32'h0000_0344);
        check_value("ar count", ar_count, ar0 + 1);
        check_value("araddr", last_araddr, 32'h0000_0344 & ~32'h1f);
        check_value("arlen", 32'(last_arlen), 32'd7);
        load(32'h0000_0358);                // same line so no new burst
        check_value("ar count", ar_count, ar0 + 1);
    endtask

    task automatic store_hit_merge();
        int ar0;
        ar0 = ar_count;
        store(32'h0000_0348, 32'hdead_beef, 4'b0101);
        load(32'h0000_0348);
        check_value("ar count", ar_count, ar0);
    endtask

    task automatic store_miss_merge();
        int ar0;
        int aw0;
        ar0 = ar_count;
        aw0 = aw_count;
        store(32'h0000_056c, 32'h1234_5678, 4'b1100);
        check_value("ar count", ar_count, ar0 + 1);
        check_value("aw count", aw_count, aw0);   // clean set
        load(32'h0000_056c);
        load(32'h0000_0570);
    endtask

    task automatic lru_replacement();
        int ar0;
        int aw0;
        load(32'h0000_0084);                // A
        load(32'h0000_1084);                // B
        load(32'h0000_0084);                // A again so B becomes the victim
        aw0 = aw_count;
        load(32'h0000_2084);                // C
        check_value("aw count", aw_count, aw0);
        ar0 = ar_count;
        load(32'h0000_0084);
        load(32'h0000_2084);
        check_value("ar count", ar_count, ar0);
        load(32'h0000_1084);
        check_value("ar count", ar_count, ar0 + 1);
        check_value("araddr", last_araddr, 32'h0000_1080);
    endtask

    task automatic dirty_eviction();
        int ar0;
        int aw0;
        int wb0;
        store(32'h0000_0128, 32'hcafe_f00d, 4'hf);
        load(32'h0000_1128);
        aw0 = aw_count;
        wb0 = w_beats;
        load(32'h0000_2128);                // evicts the dirty line
        check_value("aw count", aw_count, aw0 + 1);
        check_value("awaddr", last_awaddr, 32'h0000_0120);
        check_value("write beats", w_beats, wb0 + 8);
        check_line_in_memory(32'h0000_0120);
        ar0 = ar_count;
        load(32'h0000_0128);
        check_value("ar count", ar_count, ar0 + 1);
    endtask

    task automatic random_traffic();
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  strb;
        logic        is_st;
        int          tag_sel;
        for (int n = 0; n < 300; n++) begin
            test_seed = lcg_next(test_seed);
            is_st = test_seed[31];
            tag_sel = int'(test_seed[27:24]) % 3;
            a = (32'(tag_sel) << 12) | (32'(60 + int'(test_seed[21:20])) << 5)
                | (32'(test_seed[18:16]) << 2);
            test_seed = lcg_next(test_seed);
            d = test_seed;
            strb = is_st ? test_seed[23:20] : 4'h0;
            access(is_st, a, d, strb);
        end
    endtask

    always #20 clk = ~clk;

    always @(negedge clk) begin
        delay_seed = lcg_next(delay_seed);
        hold = delay_seed[20:18] < 3'd3;    // ready low about a third of the time
    end

    // bus monitor counts handshakes at the edge they happen
    always @(posedge clk) begin
        if (!rst) begin
            if (arvalid && arready) begin
                check_value("arsize", 32'(arsize), 32'd2);  // 4-byte beats
                ar_count <= ar_count + 1;
                last_araddr <= araddr;
                last_arlen <= arlen;
            end
            if (awvalid && awready) begin
                check_value("awlen", 32'(awlen), 32'd7);
                check_value("awsize", 32'(awsize), 32'd2);
                aw_count <= aw_count + 1;
                last_awaddr <= awaddr;
            end
            if (wvalid && wready) begin
                check_value("wlast", 32'(wlast), 32'(w_pos == 7));
                w_beats <= w_beats + 1;
                w_pos <= (w_pos == 7) ? 0 : w_pos + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    initial begin
        rst = 1'b1;
        req = 1'b0;
        we = 1'b0;
        wstrb = 4'h0;
        addr = '0;
        wdata = '0;
        peek_addr = '0;
        test_seed = 32'd71;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = init_word(32'(i) << 2);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        idle_after_reset();
        cold_load();
        store_hit_merge();
        store_miss_merge();
        lru_replacement();
        dirty_eviction();
        random_traffic();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/mem_model.sv */
`default_nettype none

module mem_model (
    input  wire         clk,
    input  wire         rst,
    input  wire         hold,           // random back-pressure from the testbench
    input  wire  [31:0] araddr,
    input  wire  [7:0]  arlen,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata_m,
    output logic        rlast,
    output logic        rvalid,
    input  wire         rready,
    input  wire  [31:0] awaddr,
    input  wire         awvalid,
    output logic        awready,
    input  wire  [31:0] wdata_m,
    input  wire  [3:0]  wstrb_m,
    input  wire         wlast,
    input  wire         wvalid,
    output logic        wready,
    output logic        bvalid,
    input  wire  [31:0] peek_addr,
    output logic [31:0] peek_data
);

    timeunit 1ns;
    timeprecision 1ns;

    localparam int WORDS = 16384;       // 64 KB window

    logic [31:0] mem [WORDS];
    logic        rd_busy = 1'b0;
    logic [31:0] rd_addr = '0;
    logic [7:0]  rd_left = '0;
    logic        wr_busy = 1'b0;
    logic [31:0] wr_addr = '0;

    // preload value from the full byte address
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h0bad_f00d;
    endfunction

    initial begin
        rvalid = 1'b0;
        bvalid = 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = init_word(32'(i) << 2);
        end
    end

    assign arready = !rd_busy && !hold;
    assign awready = !wr_busy && !bvalid && !hold;
    assign wready = wr_busy && !hold;
    assign rdata_m = mem[rd_addr[15:2]];
    assign rlast = (rd_left == 8'd0);
    assign peek_data = mem[peek_addr[15:2]];

    always @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            rvalid <= 1'b0;
            wr_busy <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            bvalid <= 1'b0;
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_addr <= araddr;
                rd_left <= arlen;
            end
            if (rvalid && rready) begin
                rd_addr <= rd_addr + 32'd4;
                rd_left <= rd_left - 8'd1;
                if (rlast) begin
                    rd_busy <= 1'b0;
                end
                rvalid <= !rlast && !hold;
            end else if (rd_busy) begin
                rvalid <= rvalid || !hold;  // once up, held until taken
            end
            if (awvalid && awready) begin
                wr_busy <= 1'b1;
                wr_addr <= awaddr;
            end
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb_m[b]) begin
                        mem[wr_addr[15:2]][b*8 +: 8] <= wdata_m[b*8 +: 8];
                    end
                end
                wr_addr <= wr_addr + 32'd4;
                if (wlast) begin
                    wr_busy <= 1'b0;
                    bvalid <= 1'b1;         // one-cycle response
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache.sv */
`default_nettype none

`include "dcache_params.svh"

module dcache (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       req,
    input  wire                       we,
    input  wire  [3:0]                wstrb,
    input  wire dcache_pkg::dc_addr_u addr,
    input  wire  [31:0]               wdata,
    output logic [31:0]               rdata,
    output logic                      stall,

    output logic [31:0]               araddr,
    output logic [7:0]                arlen,
    output logic [2:0]                arsize,
    output logic                      arvalid,
    input  wire                       arready,
    input  wire  [31:0]               rdata_m,
    input  wire                       rlast,
    input  wire                       rvalid,
    output logic                      rready,
    output logic [31:0]               awaddr,
    output logic [7:0]                awlen,
    output logic [2:0]                awsize,
    output logic                      awvalid,
    input  wire                       awready,
    output logic [31:0]               wdata_m,
    output logic [3:0]                wstrb_m,
    output logic                      wlast,
    output logic                      wvalid,
    input  wire                       wready,
    input  wire                       bvalid
);

    import dcache_pkg::*;

    logic            accept;
    logic            s_valid;
    logic            s_we;
    logic [3:0]      s_wstrb;
    dc_addr_u        s_addr;
    logic [31:0]     s_wdata;

    tag_t            tag_q [`DC_WAYS];
    logic [31:0]     data_q [`DC_WAYS];
    logic [`DC_WAYS-1:0] valid_q;
    logic [`DC_WAYS-1:0] dirty_q;
    logic [`DC_WAYS-1:0] hit_way;
    way_t            lru_way;
    way_t            hit_idx;
    way_t            use_way;
    logic            hit;
    logic            hit_store;

    logic            data_re;
    line_word_addr_t data_raddr;
    line_word_addr_t data_waddr;
    logic [31:0]     data_wdata;
    logic [31:0]     fill_data;
    logic [31:0]     rdata_base;

    logic            mc_start;
    logic            mc_busy;
    logic            mc_done;
    logic            mc_wr_en;
    word_sel_t       mc_rd_word;
    word_sel_t       mc_wr_word;
    logic [31:0]     mc_fill_word;
    logic [31:0]     mc_crit_word;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[b*8 +: 8] = strb[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
        end
        return res;
    endfunction

    assign accept = req && !stall;

    // compare stage
    always_ff @(posedge clk) begin
        if (rst) begin
            s_valid <= 1'b0;
        end else if (!stall) begin
            s_valid <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s_we <= we;
            s_wstrb <= wstrb;
            s_addr <= addr;
            s_wdata <= wdata;
        end
    end

    assign hit = s_valid && (|hit_way);
    assign hit_idx = hit_way[1];
    assign hit_store = hit && s_we;

    // miss end is the single done cycle
    assign stall = s_valid && !hit && !mc_done;
    assign mc_start = s_valid && !hit && !mc_busy && !mc_done;

    // victim read owns the read port while a miss runs
    assign data_re = accept || mc_busy;
    assign data_raddr = mc_busy ? {s_addr.f.index, mc_rd_word} : {addr.f.index, addr.f.word};
    assign data_waddr = {s_addr.f.index, hit_store ? s_addr.f.word : mc_wr_word};

    assign fill_data = (s_we && mc_wr_word == s_addr.f.word) ?
                       merge_bytes(mc_fill_word, s_wdata, s_wstrb) : mc_fill_word;
    assign data_wdata = hit_store ? s_wdata : fill_data;

    assign rdata_base = mc_done ? mc_crit_word : data_q[hit_idx];
    assign rdata = s_we ? merge_bytes(rdata_base, s_wdata, s_wstrb) : rdata_base;

    for (genvar w = 0; w < `DC_WAYS; w++) begin : way_g
        logic [3:0] data_mask;

        assign hit_way[w] = valid_q[w] && (tag_q[w] == s_addr.f.tag);
        assign data_mask = hit_store ? (s_wstrb & {4{hit_way[w]}}) :
                           {4{mc_wr_en && (lru_way == way_t'(w))}};

        cache_ram #(
            .WIDTH     (`DC_TAG_BITS),
            .ADDR_BITS (`DC_INDEX_BITS)
        ) i_tag_ram (
            .clk   (clk),
            .we    (mc_done),                   // new tag once the line is in
            .wmask (lru_way == way_t'(w)),
            .waddr (s_addr.f.index),
            .wdata (s_addr.f.tag),
            .re    (accept),
            .raddr (addr.f.index),
            .rdata (tag_q[w])
        );

        cache_ram #(
            .WIDTH     (32),
            .ADDR_BITS (`DC_INDEX_BITS + `DC_WORD_BITS)
        ) i_data_ram (
            .clk   (clk),
            .we    (hit_store || mc_wr_en),
            .wmask (data_mask),
            .waddr (data_waddr),
            .wdata (data_wdata),
            .re    (data_re),
            .raddr (data_raddr),
            .rdata (data_q[w])
        );
    end

    assign use_way = mc_done ? lru_way : hit_idx;

    set_state i_set_state (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (accept),
        .rd_index  (addr.f.index),
        .valid     (valid_q),
        .dirty     (dirty_q),
        .lru_way   (lru_way),
        .upd       (hit || mc_done),
        .upd_index (s_addr.f.index),
        .use_way   (use_way),
        .set_dirty (s_we),
        .clr_dirty (mc_done && !s_we),   // clean refill
        .fill      (mc_done)
    );

    miss_ctrl i_miss_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start        (mc_start),
        .victim_dirty (dirty_q),
        .miss_addr    (s_addr),
        .victim_tag   (tag_q[lru_way]),
        .way          (lru_way),
        .is_store     (s_we),
        .ram_word     (data_q[lru_way]),
        .araddr       (araddr),
        .arlen        (arlen),
        .arsize       (arsize),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata_m      (rdata_m),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready),
        .awaddr       (awaddr),
        .awlen        (awlen),
        .awsize       (awsize),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata_m      (wdata_m),
        .wstrb_m      (wstrb_m),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .ram_rd_word  (mc_rd_word),
        .ram_wr_en    (mc_wr_en),
        .ram_wr_word  (mc_wr_word),
        .fill_word    (mc_fill_word),
        .crit_word    (mc_crit_word),
        .busy         (mc_busy),
        .done         (mc_done)
    );

endmodule

`default_nettype wire

/* hdl/miss_ctrl.sv */
`default_nettype none

`include "dcache_params.svh"

module miss_ctrl (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start,
    input  wire  [`DC_WAYS-1:0]       victim_dirty,
    input  wire dcache_pkg::dc_addr_u miss_addr,
    input  wire dcache_pkg::tag_t     victim_tag,
    input  wire dcache_pkg::way_t     way,
    input  wire                       is_store,
    input  wire  [31:0]               ram_word,

    output logic [31:0]               araddr,
    output logic [7:0]                arlen,
    output logic [2:0]                arsize,
    output logic                      arvalid,
    input  wire                       arready,
    input  wire  [31:0]               rdata_m,
    input  wire                       rlast,
    input  wire                       rvalid,
    output logic                      rready,
    output logic [31:0]               awaddr,
    output logic [7:0]                awlen,
    output logic [2:0]                awsize,
    output logic                      awvalid,
    input  wire                       awready,
    output logic [31:0]               wdata_m,
    output logic [3:0]                wstrb_m,
    output logic                      wlast,
    output logic                      wvalid,
    input  wire                       wready,
    input  wire                       bvalid,

    output dcache_pkg::word_sel_t     ram_rd_word,
    output logic                      ram_wr_en,
    output dcache_pkg::word_sel_t     ram_wr_word,
    output logic [31:0]               fill_word,
    output logic [31:0]               crit_word,
    output logic                      busy,
    output logic                      done
);

    import dcache_pkg::*;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_VREAD  = 2'd1;
    localparam logic [1:0] S_WB     = 2'd2;
    localparam logic [1:0] S_REFILL = 2'd3;

    localparam word_sel_t LAST_WORD = word_sel_t'(`DC_WORDS - 1);

    logic [1:0]          state;
    logic [`DC_WORD_BITS:0] vcnt;          // nine cycles, ram latency of one
    word_sel_t           vslot;
    logic [31:0]         vbuf [`DC_WORDS];
    word_sel_t           beat;
    logic                tail;
    logic                r_hs;
    logic                crit_beat;

    assign arlen  = 8'(`DC_BURST_LEN);
    assign awlen  = 8'(`DC_BURST_LEN);
    assign arsize = `DC_BUS_SIZE;
    assign awsize = `DC_BUS_SIZE;
    assign wstrb_m = 4'hf;                  // whole line goes back

    // line-aligned addresses, both held steady for the whole miss
    assign araddr = {miss_addr.raw[31:`DC_LINE_BITS], {`DC_LINE_BITS{1'b0}}};
    assign awaddr = {victim_tag, miss_addr.f.index, {`DC_LINE_BITS{1'b0}}};

    assign wdata_m = vbuf[beat];
    assign wlast = wvalid && (beat == LAST_WORD);

    assign ram_rd_word = vcnt[`DC_WORD_BITS-1:0];
    assign vslot = word_sel_t'(vcnt - 1'b1);

    assign r_hs = rvalid && rready;
    assign crit_beat = r_hs && (beat == miss_addr.f.word);

    // a store's word lands in the tail cycle, merged from crit_word
    assign ram_wr_en = (r_hs && !(is_store && crit_beat)) || (tail && is_store);
    assign ram_wr_word = tail ? miss_addr.f.word : beat;
    assign fill_word = tail ? crit_word : rdata_m;

    assign busy = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            vcnt <= '0;
            beat <= '0;
            tail <= 1'b0;
            done <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        beat <= '0;
                        if (victim_dirty[way]) begin
                            state <= S_VREAD;
                            vcnt <= '0;
                        end else begin
                            state <= S_REFILL;
                            arvalid <= 1'b1;
                        end
                    end
                end
                S_VREAD: begin
                    vcnt <= vcnt + 1'b1;
                    if (vcnt == `DC_WORDS) begin   // last word captured
                        state <= S_WB;
                        awvalid <= 1'b1;
                    end
                end
                S_WB: begin
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        wvalid <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        if (beat == LAST_WORD) begin
                            wvalid <= 1'b0;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                    if (bvalid) begin
                        state <= S_REFILL;
                        arvalid <= 1'b1;
                        beat <= '0;
                    end
                end
                S_REFILL: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                    end
                    if (r_hs) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            rready <= 1'b0;
                            tail <= 1'b1;
                        end
                    end
                    if (tail) begin
                        tail <= 1'b0;
                        done <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_VREAD && vcnt != '0) begin
            vbuf[vslot] <= ram_word;
        end
        if (crit_beat) begin
            crit_word <= rdata_m;   // requested word
        end
    end

endmodule

`default_nettype wire

/* hdl/set_state.sv */
`default_nettype none

`include "dcache_params.svh"

module set_state (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     rd_en,
    input  wire dcache_pkg::index_t rd_index,
    output logic [`DC_WAYS-1:0]     valid,
    output logic [`DC_WAYS-1:0]     dirty,
    output dcache_pkg::way_t        lru_way,
    input  wire                     upd,
    input  wire dcache_pkg::index_t upd_index,
    input  wire dcache_pkg::way_t   use_way,
    input  wire                     set_dirty,
    input  wire                     clr_dirty,
    input  wire                     fill
);

    localparam int SETS = 1 << `DC_INDEX_BITS;

    logic [`DC_WAYS-1:0] valid_a [SETS];
    logic [`DC_WAYS-1:0] dirty_a [SETS];
    logic                lru_a [SETS];      // victim way per set

    logic [`DC_WAYS-1:0] nxt_valid;
    logic [`DC_WAYS-1:0] nxt_dirty;
    logic                fwd;

    // entry after the pending update
    always_comb begin
        nxt_valid = valid_a[upd_index];
        nxt_dirty = dirty_a[upd_index];
        if (fill) begin
            nxt_valid[use_way] = 1'b1;
        end
        if (set_dirty) begin
            nxt_dirty[use_way] = 1'b1;
        end else if (clr_dirty) begin
            nxt_dirty[use_way] = 1'b0;
        end
    end

    assign fwd = upd && (upd_index == rd_index);  // lookup of the set being updated

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_a[s] <= '0;
                dirty_a[s] <= '0;
                lru_a[s] <= 1'b0;
            end
            valid <= '0;
            dirty <= '0;
            lru_way <= '0;
        end else begin
            if (upd) begin
                valid_a[upd_index] <= nxt_valid;
                dirty_a[upd_index] <= nxt_dirty;
                lru_a[upd_index] <= ~use_way;   // other way becomes victim
            end
            if (rd_en) begin
                valid <= fwd ? nxt_valid : valid_a[rd_index];
                dirty <= fwd ? nxt_dirty : dirty_a[rd_index];
                lru_way <= fwd ? ~use_way : lru_a[rd_index];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_ram.sv */
`default_nettype none

module cache_ram #(
    parameter int WIDTH = 32,
    parameter int ADDR_BITS = 10,
    localparam int LANES = (WIDTH % 8 == 0) ? WIDTH / 8 : 1
) (
    input  wire                  clk,
    input  wire                  we,
    input  wire  [LANES-1:0]     wmask,
    input  wire  [ADDR_BITS-1:0] waddr,
    input  wire  [WIDTH-1:0]     wdata,
    input  wire                  re,
    input  wire  [ADDR_BITS-1:0] raddr,
    output logic [WIDTH-1:0]     rdata
);

    localparam int LANE_W = WIDTH / LANES;   // 8 for data, full width for tags

    logic [WIDTH-1:0] mem [2**ADDR_BITS];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < LANES; i++) begin
                if (wmask[i]) begin
                    mem[waddr][i*LANE_W +: LANE_W] <= wdata[i*LANE_W +: LANE_W];
                end
            end
        end
        // write-first, a same-edge write shows up on the read port
        if (re) begin
            for (int i = 0; i < LANES; i++) begin
                if (we && wmask[i] && waddr == raddr) begin
                    rdata[i*LANE_W +: LANE_W] <= wdata[i*LANE_W +: LANE_W];
                end else begin
                    rdata[i*LANE_W +: LANE_W] <= mem[raddr][i*LANE_W +: LANE_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_pkg.sv */
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_BITS-1:0] tag_t;
    typedef logic [`DC_INDEX_BITS-1:0] index_t;
    typedef logic [`DC_WORD_BITS-1:0] word_sel_t;

    // data ram address, index then word
    typedef logic [`DC_INDEX_BITS+`DC_WORD_BITS-1:0] line_word_addr_t;

    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

    // raw bus address or lookup fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            tag_t       tag;
            index_t     index;
            word_sel_t  word;
            logic [1:0] byte_sel;
        } f;
    } dc_addr_u;

endpackage

`default_nettype wire

/* hdl/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// line geometry, 32-byte lines
`define DC_LINE_BITS 5
`define DC_WORD_BITS (`DC_LINE_BITS - 2)
`define DC_WORDS 8

// 128 sets, two ways
`define DC_INDEX_BITS 7
`define DC_WAYS 2
`define DC_TAG_BITS (32 - `DC_LINE_BITS - `DC_INDEX_BITS)

// burst length code and 4-byte beat size code
`define DC_BURST_LEN (`DC_WORDS - 1)
`define DC_BUS_SIZE 3'd2

`endif
